//--- include/nes_rec_defs.svh
`ifndef NES_REC_DEFS_SVH
`define NES_REC_DEFS_SVH

// Size of the shadow image in bytes
`define NES_REC_MEM_DEPTH 512

// Image region bases

// Sprite memory copy
`define NES_REC_OAM_BASE 'h000

// PPUCTRL, PPUMASK, OAMADDR, scroll X and scroll Y
`define NES_REC_PPU_BASE 'h100

// APU and IO register copy
`define NES_REC_APU_BASE 'h140

// Watched CPU bus addresses

// First PPU register, $2000
`define NES_REC_PPU_FIRST 'h2000

// APU and IO block, $4000 up to $4015 inclusive
`define NES_REC_APU_FIRST 'h4000
`define NES_REC_APU_LAST 'h4015

`endif

//--- verilog/nes_rec_pkg.sv
`include "nes_rec_defs.svh"

package nes_rec_pkg;

    // 6502 address bus
    typedef logic [15:0] cpu_addr_t;

    // Data bus byte, also one image byte
    typedef logic [7:0] byte_t;

    // Index into the shadow image
    typedef logic [$clog2(`NES_REC_MEM_DEPTH)-1:0] mem_addr_t;

    // Decoded bus cycle kinds
    typedef enum logic [2:0] {
        // Write to $2004
        EV_OAM_DATA    = 3'd0,
        // Write to $2000
        EV_PPU_CTRL    = 3'd1,
        // Write to $2001
        EV_PPU_MASK    = 3'd2,
        // Write to $2003
        EV_OAM_ADDR    = 3'd3,
        // Write to $2005
        EV_SCROLL      = 3'd4,
        // Write to $2006, only the toggle matters
        EV_PPU_ADDR    = 3'd5,
        // Read of $2002
        EV_STATUS_READ = 3'd6,
        // Write anywhere in $4000 to $4015
        EV_APU         = 3'd7
    } bus_event_e;

    // Host readout FSM
    typedef enum logic {
        // Waiting for a request
        IDLE = 1'b0,
        // Read issued, response pending
        RESP = 1'b1
    } readout_state_e;

endpackage

//--- verilog/bus_event_if.sv
interface bus_event_if;
    import nes_rec_pkg::*;

    // One decoded register event per cycle, no back-pressure
    logic       valid;
    bus_event_e kind;
    // Offset from $4000 for APU writes
    logic [4:0] apu_index;
    byte_t      data;

    modport decoder_mp (
        output valid,
        output kind,
        output apu_index,
        output data
    );

    // Tracker takes each event in the cycle it shows up
    modport tracker_mp (
        input valid,
        input kind,
        input apu_index,
        input data
    );

endinterface

//--- verilog/cpu_bus_decoder.sv
`include "nes_rec_defs.svh"

module cpu_bus_decoder (
    input  logic                  m2,
    input  logic                  reset,
    input  nes_rec_pkg::cpu_addr_t cpu_addr,
    input  nes_rec_pkg::byte_t     cpu_data,
    input  logic                  cpu_rw,
    bus_event_if.decoder_mp       ev
);
    import nes_rec_pkg::*;

    // Watched PPU registers
    localparam cpu_addr_t ADDR_PPUCTRL   = cpu_addr_t'(`NES_REC_PPU_FIRST);
    localparam cpu_addr_t ADDR_PPUMASK   = cpu_addr_t'(`NES_REC_PPU_FIRST + 1);
    localparam cpu_addr_t ADDR_PPUSTATUS = cpu_addr_t'(`NES_REC_PPU_FIRST + 2);
    localparam cpu_addr_t ADDR_OAMADDR   = cpu_addr_t'(`NES_REC_PPU_FIRST + 3);
    localparam cpu_addr_t ADDR_OAMDATA   = cpu_addr_t'(`NES_REC_PPU_FIRST + 4);
    localparam cpu_addr_t ADDR_PPUSCROLL = cpu_addr_t'(`NES_REC_PPU_FIRST + 5);
    localparam cpu_addr_t ADDR_PPUADDR   = cpu_addr_t'(`NES_REC_PPU_FIRST + 6);

    // APU and IO window
    localparam cpu_addr_t ADDR_APU_FIRST = cpu_addr_t'(`NES_REC_APU_FIRST);
    localparam cpu_addr_t ADDR_APU_LAST  = cpu_addr_t'(`NES_REC_APU_LAST);

    logic       hit;
    bus_event_e kind_d;
    cpu_addr_t  apu_off;

    // Offset into the APU block, only low 5 bits are kept
    assign apu_off = cpu_addr - ADDR_APU_FIRST;

    // Classify the current m2 cycle
    always_comb begin
        hit    = 1'b0;
        kind_d = EV_OAM_DATA;
        if (cpu_rw) begin
            // Only the status read has a side effect we track
            if (cpu_addr == ADDR_PPUSTATUS) begin
                hit    = 1'b1;
                kind_d = EV_STATUS_READ;
            end
        end else begin
            hit = 1'b1;
            case (cpu_addr)
                ADDR_PPUCTRL:   kind_d = EV_PPU_CTRL;
                ADDR_PPUMASK:   kind_d = EV_PPU_MASK;
                ADDR_OAMADDR:   kind_d = EV_OAM_ADDR;
                ADDR_OAMDATA:   kind_d = EV_OAM_DATA;
                ADDR_PPUSCROLL: kind_d = EV_SCROLL;
                ADDR_PPUADDR:   kind_d = EV_PPU_ADDR;
                default: begin
                    // Mirrors and everything else are ignored
                    if (cpu_addr >= ADDR_APU_FIRST && cpu_addr <= ADDR_APU_LAST) begin
                        kind_d = EV_APU;
                    end else begin
                        hit = 1'b0;
                    end
                end
            endcase
        end
    end

    // Event strobe
    always_ff @(posedge m2) begin
        if (reset) begin
            ev.valid <= 1'b0;
        end else begin
            ev.valid <= hit;
        end
    end

    // Event payload, held between hits
    always_ff @(posedge m2) begin
        if (hit) begin
            ev.kind      <= kind_d;
            ev.apu_index <= apu_off[4:0];
            ev.data      <= cpu_data;
        end
    end

    // Tracker relies on a known kind for every strobed event
    a_kind_defined: assert property (
        @(posedge m2) disable iff (reset)
        ev.valid |-> !$isunknown(ev.kind)
    );

endmodule

//--- verilog/ppu_shadow_tracker.sv
`include "nes_rec_defs.svh"

module ppu_shadow_tracker (
    input  logic                   m2,
    input  logic                   reset,
    bus_event_if.tracker_mp        ev,
    output logic                   ram_we,
    output nes_rec_pkg::mem_addr_t ram_waddr,
    output nes_rec_pkg::byte_t     ram_wdata
);
    import nes_rec_pkg::*;

    // Fixed image slots in the PPU region
    localparam mem_addr_t SLOT_CTRL     = mem_addr_t'(`NES_REC_PPU_BASE);
    localparam mem_addr_t SLOT_MASK     = mem_addr_t'(`NES_REC_PPU_BASE + 1);
    localparam mem_addr_t SLOT_OAM_ADDR = mem_addr_t'(`NES_REC_PPU_BASE + 2);
    localparam mem_addr_t SLOT_SCROLL_X = mem_addr_t'(`NES_REC_PPU_BASE + 3);
    localparam mem_addr_t SLOT_SCROLL_Y = mem_addr_t'(`NES_REC_PPU_BASE + 4);

    // Region bases
    localparam mem_addr_t OAM_BASE = mem_addr_t'(`NES_REC_OAM_BASE);
    localparam mem_addr_t APU_BASE = mem_addr_t'(`NES_REC_APU_BASE);

    // Sprite pointer, wraps at 256 by width
    byte_t oam_ptr;
    // Shared $2005/$2006 first/second write latch
    logic  write_toggle;

    // Pointer and toggle side effects
    always_ff @(posedge m2) begin
        if (reset) begin
            oam_ptr      <= '0;
            write_toggle <= 1'b0;
        end else if (ev.valid) begin
            case (ev.kind)
                EV_OAM_DATA:    oam_ptr <= oam_ptr + 8'd1;
                EV_OAM_ADDR:    oam_ptr <= ev.data;
                EV_SCROLL:      write_toggle <= ~write_toggle;
                EV_PPU_ADDR:    write_toggle <= ~write_toggle;
                EV_STATUS_READ: write_toggle <= 1'b0;
                default: ;
            endcase
        end
    end

    // Write strobe, low for events with no image byte
    always_ff @(posedge m2) begin
        if (reset) begin
            ram_we <= 1'b0;
        end else begin
            ram_we <= ev.valid && ev.kind != EV_PPU_ADDR && ev.kind != EV_STATUS_READ;
        end
    end

    // Target slot and byte
    always_ff @(posedge m2) begin
        ram_wdata <= ev.data;
        case (ev.kind)
            EV_OAM_DATA: ram_waddr <= OAM_BASE + mem_addr_t'(oam_ptr);
            EV_PPU_CTRL: ram_waddr <= SLOT_CTRL;
            EV_PPU_MASK: ram_waddr <= SLOT_MASK;
            EV_OAM_ADDR: ram_waddr <= SLOT_OAM_ADDR;
            // X on first write, Y on second
            EV_SCROLL:   ram_waddr <= write_toggle ? SLOT_SCROLL_Y : SLOT_SCROLL_X;
            EV_APU:      ram_waddr <= APU_BASE + mem_addr_t'(ev.apu_index);
            default:     ram_waddr <= ram_waddr;
        endcase
    end

    // Every write lands inside the image, in a mapped slot
    a_waddr_in_range: assert property (
        @(posedge m2) disable iff (reset)
        ram_we |-> (int'(ram_waddr) < `NES_REC_MEM_DEPTH
            && (ram_waddr <= SLOT_SCROLL_Y
                || (ram_waddr >= APU_BASE
                    && int'(ram_waddr - APU_BASE) <= `NES_REC_APU_LAST - `NES_REC_APU_FIRST)))
    );

endmodule

//--- verilog/state_ram.sv
`include "nes_rec_defs.svh"

module state_ram (
    input  logic                   m2,
    input  logic                   we,
    input  nes_rec_pkg::mem_addr_t waddr,
    input  nes_rec_pkg::byte_t     wdata,
    input  logic                   re,
    input  nes_rec_pkg::mem_addr_t raddr,
    output nes_rec_pkg::byte_t     rdata
);
    import nes_rec_pkg::*;

    // Image storage, maps to a block RAM
    byte_t mem [`NES_REC_MEM_DEPTH];

    // Tracker write port
    always_ff @(posedge m2) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read port
    // Same-address collision returns the old byte
    // rdata keeps its value while re is low
    always_ff @(posedge m2) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

//--- verilog/readout_port.sv
module readout_port (
    input  logic                   m2,
    input  logic                   reset,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  nes_rec_pkg::mem_addr_t req_addr,
    output logic                   ram_re,
    output nes_rec_pkg::mem_addr_t ram_raddr,
    input  nes_rec_pkg::byte_t     ram_rdata,
    output logic                   resp_valid,
    input  logic                   resp_ready,
    output nes_rec_pkg::byte_t     resp_data
);
    import nes_rec_pkg::*;

    readout_state_e state;

    // One read in flight, so only accept from IDLE
    assign req_ready = (state == IDLE);

    // RAM read goes out with the accepted request
    assign ram_re    = req_valid && req_ready;
    assign ram_raddr = req_addr;

    // Readout FSM
    always_ff @(posedge m2) begin
        if (reset) begin
            state      <= IDLE;
            resp_valid <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (ram_re) begin
                        state <= RESP;
                    end
                end
                RESP: begin
                    if (!resp_valid) begin
                        // RAM byte arrived on the previous edge
                        resp_valid <= 1'b1;
                    end else if (resp_ready) begin
                        resp_valid <= 1'b0;
                        state      <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Capture once, then hold through back-pressure
    always_ff @(posedge m2) begin
        if (state == RESP && !resp_valid) begin
            resp_data <= ram_rdata;
        end
    end

    // Stalled response must not move
    a_resp_stable: assert property (
        @(posedge m2) disable iff (reset)
        (resp_valid && !resp_ready) |=> (resp_valid && $stable(resp_data))
    );

    // No new request while a response is pending
    a_no_accept_in_resp: assert property (
        @(posedge m2) disable iff (reset)
        resp_valid |-> !req_ready
    );

endmodule

//--- verilog/nes_state_recorder.sv
module nes_state_recorder (
    input  logic                    m2,
    input  logic                    reset,

    // Bus sniffing
    input  nes_rec_pkg::cpu_addr_t  cpu_addr,
    input  nes_rec_pkg::byte_t      cpu_data,
    input  logic                    cpu_rw,

    // Host request
    input  logic                    req_valid,
    output logic                    req_ready,
    input  nes_rec_pkg::mem_addr_t  req_addr,

    // Host response
    output logic                    resp_valid,
    input  logic                    resp_ready,
    output nes_rec_pkg::byte_t      resp_data
);
    import nes_rec_pkg::*;

    // Decoder to tracker
    bus_event_if ev ();

    // Tracker write port
    logic      ram_we;
    mem_addr_t ram_waddr;
    byte_t     ram_wdata;

    // Readout read port
    logic      ram_re;
    mem_addr_t ram_raddr;
    byte_t     ram_rdata;

    cpu_bus_decoder u_decoder (
        .m2       (m2),
        .reset    (reset),
        .cpu_addr (cpu_addr),
        .cpu_data (cpu_data),
        .cpu_rw   (cpu_rw),
        .ev       (ev.decoder_mp)
    );

    ppu_shadow_tracker u_tracker (
        .m2        (m2),
        .reset     (reset),
        .ev        (ev.tracker_mp),
        .ram_we    (ram_we),
        .ram_waddr (ram_waddr),
        .ram_wdata (ram_wdata)
    );

    state_ram u_ram (
        .m2    (m2),
        .we    (ram_we),
        .waddr (ram_waddr),
        .wdata (ram_wdata),
        .re    (ram_re),
        .raddr (ram_raddr),
        .rdata (ram_rdata)
    );

    readout_port u_readout (
        .m2         (m2),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_addr   (req_addr),
        .ram_re     (ram_re),
        .ram_raddr  (ram_raddr),
        .ram_rdata  (ram_rdata),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp_data  (resp_data)
    );

endmodule

//--- test/tb_nes_state_recorder.sv
`include "nes_rec_defs.svh"

module tb_nes_state_recorder;
    timeunit 1ns;
    timeprecision 100ps;
    import nes_rec_pkg::*;

    // Run length
    localparam int BUS_LEN     = 40;
    localparam int READS       = 16;
    localparam int ROUNDS      = 12;
    // Typical cost of one readout including an average stall
    localparam int READ_CYCLES = 5;
    localparam int INIT_BUS    = 1 + 300 + 2 + 1 + 2 + 22;
    localparam int INIT_READS  = 256 + 5 + 22;
    localparam int PLANNED     = 4 + INIT_BUS + 3 + INIT_READS * READ_CYCLES
                               + ROUNDS * (BUS_LEN + 6 + (READS + 3) * READ_CYCLES);
    localparam int CYCLE_LIMIT = 2 * PLANNED;

    // Image layout
    localparam mem_addr_t OAM_BASE = mem_addr_t'(`NES_REC_OAM_BASE);
    localparam mem_addr_t PPU_BASE = mem_addr_t'(`NES_REC_PPU_BASE);
    localparam mem_addr_t APU_BASE = mem_addr_t'(`NES_REC_APU_BASE);

    logic      m2;
    logic      reset;
    cpu_addr_t cpu_addr;
    byte_t     cpu_data;
    logic      cpu_rw;
    logic      req_valid;
    logic      req_ready;
    mem_addr_t req_addr;
    logic      resp_valid;
    logic      resp_ready;
    byte_t     resp_data;

    // Reference image with its own pointer and toggle
    byte_t     model_img [`NES_REC_MEM_DEPTH];
    byte_t     model_ptr;
    logic      model_toggle;

    logic [31:0] lfsr_state;
    int          cycle_count = 0;
    int          n_issued;
    int          accepted_count = 0;
    int          answered_count = 0;

    nes_state_recorder dut (
        .m2         (m2),
        .reset      (reset),
        .cpu_addr   (cpu_addr),
        .cpu_data   (cpu_data),
        .cpu_rw     (cpu_rw),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_addr   (req_addr),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp_data  (resp_data)
    );

    initial begin
        m2 = 1'b0;
        forever #5 m2 = ~m2;
    end

    // Hard stop for a hung handshake
    always @(posedge m2) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run went past %0d cycles without finishing", CYCLE_LIMIT);
            $display("TEST FAILED");
            $fatal(1, "simulation timeout");
        end
    end

    // Handshake counters, sampled away from the active edge
    always @(negedge m2) begin
        if (!reset && req_valid && req_ready) begin
            accepted_count <= accepted_count + 1;
        end
        if (!reset && resp_valid && resp_ready) begin
            answered_count <= answered_count + 1;
        end
    end

    // Taps 32, 22, 2, 1; one step per bit
    function automatic logic [31:0] lfsr_bits(input int nbits);
        logic [31:0] value;
        value = '0;
        repeat (nbits) begin
            lfsr_state = {lfsr_state[30:0],
                lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    task check_value(input string name, input logic [31:0] actual,
                     input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Register side effects as the PPU and APU define them
    task model_apply(input cpu_addr_t addr, input byte_t data, input logic rw);
        if (rw) begin
            // Reading PPUSTATUS resets the shared latch
            if (addr == 16'h2002) begin
                model_toggle = 1'b0;
            end
        end else if (addr == 16'h2000) begin
            model_img[PPU_BASE] = data;
        end else if (addr == 16'h2001) begin
            model_img[PPU_BASE + 9'd1] = data;
        end else if (addr == 16'h2003) begin
            model_img[PPU_BASE + 9'd2] = data;
            model_ptr = data;
        end else if (addr == 16'h2004) begin
            model_img[OAM_BASE + 9'(model_ptr)] = data;
            model_ptr = model_ptr + 8'd1;
        end else if (addr == 16'h2005) begin
            model_img[model_toggle ? PPU_BASE + 9'd4 : PPU_BASE + 9'd3] = data;
            model_toggle = ~model_toggle;
        end else if (addr == 16'h2006) begin
            model_toggle = ~model_toggle;
        end else if (addr >= 16'h4000 && addr <= 16'h4015) begin
            model_img[APU_BASE + 9'(addr - 16'h4000)] = data;
        end
    endtask

    task bus_cycle(input cpu_addr_t addr, input byte_t data, input logic rw);
        @(posedge m2);
        cpu_addr <= addr;
        cpu_data <= data;
        cpu_rw   <= rw;
        model_apply(addr, data, rw);
    endtask

    // Reads of CPU RAM, nothing watched
    task bus_idle(input int n);
        repeat (n) begin
            @(posedge m2);
            cpu_addr <= 16'h0000;
            cpu_data <= 8'h00;
            cpu_rw   <= 1'b1;
        end
    endtask

    task random_bus_cycle();
        logic [31:0] sel;
        logic [31:0] val;
        logic [31:0] pick;
        sel  = lfsr_bits(4);
        val  = lfsr_bits(8);
        pick = lfsr_bits(16);
        case (sel[3:0])
            4'd0, 4'd1, 4'd2: bus_cycle(16'h2004, val[7:0], 1'b0);
            4'd3:             bus_cycle(16'h2003, val[7:0], 1'b0);
            4'd4:             bus_cycle(16'h2000, val[7:0], 1'b0);
            4'd5:             bus_cycle(16'h2001, val[7:0], 1'b0);
            4'd6, 4'd7:       bus_cycle(16'h2005, val[7:0], 1'b0);
            4'd8:             bus_cycle(16'h2006, val[7:0], 1'b0);
            4'd9:             bus_cycle(16'h2002, val[7:0], 1'b1);
            4'd10, 4'd11:     bus_cycle(16'h4000 + 16'(pick % 22), val[7:0], 1'b0);
            // Reads of watched registers other than PPUSTATUS
            4'd12: begin
                if (pick[15]) begin
                    bus_cycle(16'h4000 + 16'(pick[14:0] % 22), val[7:0], 1'b1);
                end else begin
                    bus_cycle(pick[2:0] == 3'd2 ? 16'h2004 : 16'h2000 + {13'd0, pick[2:0]},
                        val[7:0], 1'b1);
                end
            end
            // CPU RAM
            4'd13: bus_cycle({3'b000, pick[12:0]}, val[7:0], 1'b0);
            // PPUDATA and register mirrors
            4'd14: bus_cycle(16'h2007 + {13'd0, pick[2:0]}, val[7:0], 1'b0);
            // Joypad and test registers past $4015
            default: bus_cycle(16'h4016 + {13'd0, pick[2:0]}, val[7:0], 1'b0);
        endcase
    endtask

    // One request, one response, random back-pressure
    task read_check(input mem_addr_t addr);
        byte_t       expected;
        byte_t       held;
        logic [31:0] r;
        logic        done;
        logic        stalled;
        int          step;
        expected = model_img[addr];
        @(posedge m2);
        req_valid <= 1'b1;
        req_addr  <= addr;
        @(negedge m2);
        while (!req_ready) begin
            @(negedge m2);
        end
        // Acceptance edge
        @(posedge m2);
        req_valid <= 1'b0;
        n_issued  = n_issued + 1;
        done      = 1'b0;
        stalled   = 1'b0;
        step      = 0;
        while (!done) begin
            r = lfsr_bits(1);
            resp_ready <= r[0];
            @(negedge m2);
            check_value("req_ready", 32'(req_ready), 32'd0);
            // Byte arrives one cycle after acceptance
            check_value("resp_valid", 32'(resp_valid), (step == 0) ? 32'd0 : 32'd1);
            if (stalled) begin
                check_value("resp_data", 32'(resp_data), 32'(held));
            end
            if (step > 0) begin
                if (resp_ready) begin
                    check_value("resp_data", 32'(resp_data), 32'(expected));
                    done = 1'b1;
                end else begin
                    stalled = 1'b1;
                    held    = resp_data;
                end
            end
            step = step + 1;
            @(posedge m2);
        end
        resp_ready <= 1'b0;
        @(negedge m2);
        // No second response, port back in IDLE
        check_value("resp_valid", 32'(resp_valid), 32'd0);
        check_value("req_ready", 32'(req_ready), 32'd1);
    endtask

    task random_read();
        logic [31:0] sel;
        logic [31:0] pick;
        sel  = lfsr_bits(2);
        pick = lfsr_bits(8);
        case (sel[1:0])
            2'd0:    read_check(OAM_BASE + 9'(pick[7:0]));
            2'd1:    read_check(PPU_BASE + 9'(pick % 5));
            2'd2:    read_check(APU_BASE + 9'(pick % 22));
            default: read_check(pick[0] ? PPU_BASE + 9'd4 : PPU_BASE + 9'd3);
        endcase
    endtask

    initial begin
        int          i;
        int          round;
        logic [31:0] val;
        byte_t       p;
        cpu_addr     <= 16'h0000;
        cpu_data     <= 8'h00;
        cpu_rw       <= 1'b1;
        req_valid    <= 1'b0;
        req_addr     <= '0;
        resp_ready   <= 1'b0;
        reset        <= 1'b1;
        lfsr_state   = 32'h7d60;
        model_ptr    = 8'h00;
        model_toggle = 1'b0;
        n_issued     = 0;
        repeat (4) @(posedge m2);
        reset <= 1'b0;

        // Fill every reachable image byte, OAM pointer wraps past 256
        bus_cycle(16'h2003, 8'h00, 1'b0);
        for (i = 0; i < 300; i++) begin
            val = lfsr_bits(8);
            bus_cycle(16'h2004, val[7:0], 1'b0);
        end
        val = lfsr_bits(8);
        bus_cycle(16'h2000, val[7:0], 1'b0);
        val = lfsr_bits(8);
        bus_cycle(16'h2001, val[7:0], 1'b0);
        bus_cycle(16'h2002, 8'h00, 1'b1);
        val = lfsr_bits(8);
        bus_cycle(16'h2005, val[7:0], 1'b0);
        val = lfsr_bits(8);
        bus_cycle(16'h2005, val[7:0], 1'b0);
        for (i = 0; i < 22; i++) begin
            val = lfsr_bits(8);
            bus_cycle(16'h4000 + 16'(i), val[7:0], 1'b0);
        end
        bus_idle(3);
        for (i = 0; i < 256; i++) begin
            read_check(OAM_BASE + 9'(i));
        end
        for (i = 0; i < 5; i++) begin
            read_check(PPU_BASE + 9'(i));
        end
        for (i = 0; i < 22; i++) begin
            read_check(APU_BASE + 9'(i));
        end

        // Random bus traffic, then a pointer load, then readout
        for (round = 0; round < ROUNDS; round++) begin
            for (i = 0; i < BUS_LEN; i++) begin
                random_bus_cycle();
            end
            val = lfsr_bits(8);
            p = val[7:0];
            bus_cycle(16'h2003, p, 1'b0);
            val = lfsr_bits(8);
            bus_cycle(16'h2004, val[7:0], 1'b0);
            val = lfsr_bits(8);
            bus_cycle(16'h2004, val[7:0], 1'b0);
            bus_idle(3);
            read_check(OAM_BASE + 9'(p));
            // Second byte wraps within OAM
            read_check(OAM_BASE + 9'(byte_t'(p + 8'd1)));
            read_check(PPU_BASE + 9'd2);
            for (i = 0; i < READS; i++) begin
                random_read();
            end
        end

        // Let the counters settle
        @(posedge m2);
        if (accepted_count != n_issued || answered_count != n_issued) begin
            $display("Handshake count wrong: %0d issued, %0d accepted, %0d answered",
                n_issued, accepted_count, answered_count);
            $display("TEST FAILED");
            $fatal(1, "handshake count");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

//--- filelist.f
+incdir+include
verilog/nes_rec_pkg.sv
verilog/bus_event_if.sv
verilog/cpu_bus_decoder.sv
verilog/ppu_shadow_tracker.sv
verilog/state_ram.sv
verilog/readout_port.sv
verilog/nes_state_recorder.sv
test/tb_nes_state_recorder.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f filelist.f --top-module tb_nes_state_recorder \
    && ./obj_dir/Vtb_nes_state_recorder 2>&1 | tee sim.log \
    || echo "Build or run did not complete" | tee -a sim.log
grep -q "TEST FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TEST OK" sim.log || { echo "Simulation did not pass"; exit 1; }
echo "Simulation passed"
exit 0
